/* sd_share.f */
sd_share_pkg.sv
sd_req_sync.sv
sd_grant_arbiter.sv
sd_spi_mux.sv
sd_share_top.sv
tb_sd_share.sv

/* tb_sd_share.sv */
// testbench for the sd card sharing hub, default parameters only
// outputs are sampled on the falling edge, inputs change on the rising edge
// reference model mirrors the request filter depth and the arbiter rule
module tb_sd_share
   import sd_share_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          CLK_PERIOD     = 4;                // ns
   localparam logic [15:0] LFSR_SEED      = 16'd41215;
   localparam int unsigned MODEL_STAGES   = DEF_SYNC_STAGES;  // filter depth in the model
   localparam int unsigned GRANT_LAT      = MODEL_STAGES + 1; // edges from drive to grant
   localparam int unsigned RAND_CYCLES    = 1200;             // random traffic phase
   localparam int unsigned TEST_CYCLES    = 1500;             // whole run, roughly
   localparam int unsigned TIMEOUT_CYCLES = 2 * TEST_CYCLES;
   localparam int unsigned WAIT_LIMIT     = 40;               // per grant change

   logic            sdclock;
   logic            arst_n_i;
   logic [N_CH-1:0] req_i, cs_i, mosi_i, sclk_i;
   logic [N_CH-1:0] grant_o;
   logic            sdcard_cs_o, sdcard_mosi_o, sdcard_sclk_o;
   logic [N_CH-1:0] led_n_o;

   logic [15:0]     lfsr = LFSR_SEED;  // random state
   logic [N_CH-1:0] req_cur;           // request levels the stimulus holds
   logic [N_CH-1:0] sync_m [MODEL_STAGES];  // model of the filter chain
   logic [N_CH-1:0] exp_grant;         // model grant register
   int unsigned     n_errors = 0;
   int unsigned     n_checks = 0;
   int unsigned     cycle_cnt = 0;

   sd_share_top i_sd_share_top (
      .sdclock       (sdclock),
      .arst_n_i      (arst_n_i),
      .req_i         (req_i),
      .cs_i          (cs_i),
      .mosi_i        (mosi_i),
      .sclk_i        (sclk_i),
      .grant_o       (grant_o),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o),
      .led_n_o       (led_n_o)
   );

   //********************
   // clock and reset
   //********************
   initial begin
      sdclock = 1'b0;
      forever #(CLK_PERIOD / 2) sdclock = ~sdclock;
   end

   initial begin
      arst_n_i = 1'b0;              // held for two edges
      repeat (2) @(posedge sdclock);
      arst_n_i <= 1'b1;
   end

   //********************
   // helpers
   //********************
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic rand_bit();
      lfsr = lfsr_step(lfsr);       // one step per bit
      return lfsr[0];
   endfunction

   function automatic logic [N_CH-1:0] onehot_of(input int unsigned ch);
      logic [N_CH-1:0] v;
      v     = '0;
      v[ch] = 1'b1;
      return v;
   endfunction

   function automatic int unsigned count_ones(input logic [N_CH-1:0] v);
      int unsigned n;
      n = 0;
      for (int c = 0; c < N_CH; c++) n += v[c];
      return n;
   endfunction

   // holder keeps the card while its filtered request stays up,
   // a free card goes to the lowest pending index
   function automatic logic [N_CH-1:0] next_grant(input logic [N_CH-1:0] req,
                                                  input logic [N_CH-1:0] cur);
      logic [N_CH-1:0] nxt;
      nxt = cur;
      if (cur != '0) begin
         for (int c = 0; c < N_CH; c++)
            if (cur[c] && !req[c]) nxt = '0;  // release, gap edge follows
      end else begin
         for (int c = N_CH - 1; c >= 0; c--)
            if (req[c]) nxt = onehot_of(c);   // lowest index ends up last
      end
      return nxt;
   endfunction

   // {cs, mosi, sclk} of the granted channel, default channel when free
   function automatic logic [2:0] exp_pins(input logic [N_CH-1:0] gnt,
                                           input logic [N_CH-1:0] cs,
                                           input logic [N_CH-1:0] mosi,
                                           input logic [N_CH-1:0] sclk);
      int unsigned ch;
      ch = DEF_CH;
      for (int c = 0; c < N_CH; c++)
         if (gnt[c]) ch = c;
      return {cs[ch], mosi[ch], sclk[ch]};
   endfunction

   task automatic check_val(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // one rising edge: new request levels and fresh random spi lines
   task automatic drive_cycle(input logic [N_CH-1:0] req);
      logic [N_CH-1:0] cs, mo, sc;
      for (int c = 0; c < N_CH; c++) begin
         cs[c] = rand_bit();
         mo[c] = rand_bit();
         sc[c] = rand_bit();
      end
      @(posedge sdclock);
      req_i  <= req;
      cs_i   <= cs;
      mosi_i <= mo;
      sclk_i <= sc;
   endtask

   task automatic idle_cycles(input int unsigned n);
      repeat (n) drive_cycle(req_cur);
   endtask

   // n counts falling edges until grant_o leaves the given value
   task automatic wait_change(input logic [N_CH-1:0] from, output int unsigned n);
      n = 0;
      do begin
         drive_cycle(req_cur);
         @(negedge sdclock);
         n++;
      end while (grant_o === from && n < WAIT_LIMIT);
      if (grant_o === from) begin
         n_errors++;
         $display("grant stayed at %b for %0d cycles, expected it to change", from, n);
      end
   endtask

   //********************
   // reference model
   //********************
   always @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         exp_grant <= '0;
         for (int s = 0; s < MODEL_STAGES; s++) sync_m[s] <= '0;
      end else begin
         exp_grant <= next_grant(sync_m[MODEL_STAGES-1], exp_grant);
         sync_m[0] <= req_i;                  // value before this edge's drive
         for (int s = 1; s < MODEL_STAGES; s++) sync_m[s] <= sync_m[s-1];
      end
   end

   //********************
   // compare and timeout
   //********************
   always @(negedge sdclock) begin
      check_val("grant_o", grant_o, exp_grant);
      check_val("grant one-hot", count_ones(grant_o) <= 1, 1);
      check_val("card pins", {sdcard_cs_o, sdcard_mosi_o, sdcard_sclk_o},
                exp_pins(exp_grant, cs_i, mosi_i, sclk_i));
      check_val("led_n_o", led_n_o, N_CH'(~req_i));
   end

   always @(posedge sdclock) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles, stopped", TIMEOUT_CYCLES);
         $display("checks: %0d, errors: %0d", n_checks, n_errors);
         $display("Simulation failed");
         $finish;
      end
   end

   //********************
   // stimulus
   //********************
   initial begin
      int unsigned n;
      logic        flip;
      req_i  = '0;
      cs_i   = '0;
      mosi_i = '0;
      sclk_i = '0;
      // requests up during reset, leds follow, grant stays off
      req_cur = 6'b010101;
      idle_cycles(1);
      req_cur = '0;
      idle_cycles(4);                           // flush the filter
      // lone request per channel, latency counted from the drive edge
      for (int c = 0; c < N_CH; c++) begin
         req_cur[c] = 1'b1;
         wait_change('0, n);
         check_val("single grant", grant_o, onehot_of(c));
         check_val("grant latency", n - 1, GRANT_LAT);
         idle_cycles(8);                        // pins follow random spi lines
         req_cur[c] = 1'b0;
         wait_change(onehot_of(c), n);
         check_val("release", grant_o, '0);
         check_val("release latency", n - 1, GRANT_LAT);
         idle_cycles(2);
      end
      // all at once, served in index order with one free edge between
      req_cur = '1;
      for (int c = 0; c < N_CH; c++) begin
         wait_change('0, n);
         check_val("priority order", grant_o, onehot_of(c));
         if (c == 0) check_val("grant latency", n - 1, GRANT_LAT);
         else check_val("gap after release", n, 1);
         idle_cycles(4);
         req_cur[c] = 1'b0;
         wait_change(onehot_of(c), n);
         check_val("release", grant_o, '0);
      end
      idle_cycles(4);
      // rk asks while db holds the card
      req_cur[CH_DB] = 1'b1;
      wait_change('0, n);
      check_val("db grant", grant_o, onehot_of(CH_DB));
      req_cur[CH_RK] = 1'b1;
      repeat (10) begin
         drive_cycle(req_cur);
         @(negedge sdclock);
         check_val("no pre-emption", grant_o, onehot_of(CH_DB));
      end
      req_cur[CH_DB] = 1'b0;
      wait_change(onehot_of(CH_DB), n);
      check_val("db release", grant_o, '0);
      check_val("db release latency", n - 1, GRANT_LAT);
      wait_change('0, n);
      check_val("rk after gap", grant_o, onehot_of(CH_RK));
      check_val("gap after release", n, 1);
      req_cur[CH_RK] = 1'b0;
      wait_change(onehot_of(CH_RK), n);
      idle_cycles(4);
      // random traffic, each request flips with odds 1 in 8
      for (int i = 0; i < RAND_CYCLES; i++) begin
         for (int c = 0; c < N_CH; c++) begin
            flip = rand_bit() & rand_bit() & rand_bit();
            if (flip) req_cur[c] = ~req_cur[c];
         end
         drive_cycle(req_cur);
      end
      req_cur = '0;
      idle_cycles(8);
      @(negedge sdclock);
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule : tb_sd_share

/* sd_share_top.sv */
// sd card sharing hub for six disk controllers on one spi card
// requests and grants are plain levels; a controller drives the card only while granted
// grant follows a raw request rise by SYNC_STAGES+1 sdclock edges
module sd_share_top
   import sd_share_pkg::*;
#(
   parameter int unsigned SYNC_STAGES = DEF_SYNC_STAGES,  // request filter depth
   parameter int unsigned IDLE_CH     = DEF_CH            // pins owner with no grant
) (
   input  logic            sdclock,        // card clock
   input  logic            arst_n_i,       // async reset, active low
   input  logic [N_CH-1:0] req_i,          // request levels from controllers
   input  logic [N_CH-1:0] cs_i,           // controller chip selects
   input  logic [N_CH-1:0] mosi_i,         // controller data out
   input  logic [N_CH-1:0] sclk_i,         // controller spi clocks
   output logic [N_CH-1:0] grant_o,        // one-hot grant back to controllers
   output logic            sdcard_cs_o,    // card pins
   output logic            sdcard_mosi_o,
   output logic            sdcard_sclk_o,
   output logic [N_CH-1:0] led_n_o         // activity leds, low = lit
);

   logic [N_CH-1:0] req_sync;  // filtered requests
   logic [N_CH-1:0] grant;     // current holder

   //********************
   // request filter
   //********************
   sd_req_sync #(
      .SYNC_STAGES (SYNC_STAGES)
   ) i_sd_req_sync (
      .sdclock    (sdclock),
      .arst_n_i   (arst_n_i),
      .req_i      (req_i),
      .req_sync_o (req_sync)
   );

   //********************
   // arbiter
   //********************
   sd_grant_arbiter i_sd_grant_arbiter (
      .sdclock    (sdclock),
      .arst_n_i   (arst_n_i),
      .req_sync_i (req_sync),
      .grant_o    (grant)
   );

   assign grant_o = grant;  // each controller watches its own bit

   //********************
   // pin mux
   //********************
   sd_spi_mux #(
      .IDLE_CH (IDLE_CH)
   ) i_sd_spi_mux (
      .grant_i       (grant),
      .cs_i          (cs_i),
      .mosi_i        (mosi_i),
      .sclk_i        (sclk_i),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o)
   );

   //********************
   // activity leds
   //********************
   // driven from the raw request, so a waiting controller lights up too
   assign led_n_o[CH_RK] = ~req_i[CH_RK];  // rk11
   assign led_n_o[CH_DW] = ~req_i[CH_DW];  // dw
   assign led_n_o[CH_DM] = ~req_i[CH_DM];  // rk611
   assign led_n_o[CH_DB] = ~req_i[CH_DB];  // rh70
   assign led_n_o[CH_DX] = ~req_i[CH_DX];  // rx01
   assign led_n_o[CH_MY] = ~req_i[CH_MY];  // my

endmodule : sd_share_top

/* sd_spi_mux.sv */
// card pin selector, purely combinational
// relies on grant_i being one-hot; with no grant the IDLE_CH lines reach the card
module sd_spi_mux
   import sd_share_pkg::*;
#(
   parameter int unsigned IDLE_CH = DEF_CH  // owner of the pins when card is free
) (
   input  logic [N_CH-1:0] grant_i,        // one-hot grant
   input  logic [N_CH-1:0] cs_i,           // chip selects from controllers
   input  logic [N_CH-1:0] mosi_i,         // data out from controllers
   input  logic [N_CH-1:0] sclk_i,         // spi clocks from controllers
   output logic            sdcard_cs_o,    // card chip select
   output logic            sdcard_mosi_o,  // card data in
   output logic            sdcard_sclk_o   // card clock
);

   //********************
   // select vector
   //********************
   // one-hot mask of the default channel
   localparam logic [N_CH-1:0] IDLE_SEL = {{(N_CH-1){1'b0}}, 1'b1} << IDLE_CH;

   logic [N_CH-1:0] sel;       // one-hot mask of the channel on the pins
   logic            no_grant;  // card free

   assign no_grant = ~|grant_i;  // nobody holds it

   // free card goes to the default controller so it can run its own
   // init sequence without asking first
   assign sel = no_grant ? IDLE_SEL : grant_i;

   //********************
   // and-or selection
   //********************
   // sel has exactly one bit set, so masking and or-reducing picks that
   // channel's line, no priority chain between grant bits needed
   assign sdcard_cs_o   = |(cs_i   & sel);  // chip select
   assign sdcard_mosi_o = |(mosi_i & sel);  // command and write data
   assign sdcard_sclk_o = |(sclk_i & sel);  // spi clock

   // miso is not routed here, it goes to every controller by wire

endmodule : sd_spi_mux

/* sd_grant_arbiter.sv */
// one-hot grant register for the shared sd card
// fixed priority by channel index when idle; a holder keeps the card until it lets go
// after a release there is always one edge with no grant before the next winner
module sd_grant_arbiter
   import sd_share_pkg::*;
(
   input  logic            sdclock,     // card clock
   input  logic            arst_n_i,    // async reset, active low
   input  logic [N_CH-1:0] req_sync_i,  // filtered requests
   output logic [N_CH-1:0] grant_o      // one-hot grant, at most one bit set
);

   //********************
   // state
   //********************
   logic [N_CH-1:0] grant_q;    // current holder, zero when card is free
   logic [N_CH-1:0] grant_nxt;  // value for the next edge
   logic [N_CH-1:0] pick;       // highest-priority pending channel
   logic            found;      // pick already has its bit
   logic            busy;       // some controller owns the card

   assign busy = |grant_q;  // one-hot, so any bit means owned

   //********************
   // priority pick
   //********************
   // walk from index 0 upwards, first pending channel wins
   always_comb begin
      pick  = '0;
      found = 1'b0;
      for (int c = 0; c < N_CH; c++) begin
         if (req_sync_i[c] && !found) begin
            pick[c] = 1'b1;  // winner
            found   = 1'b1;  // mask the rest
         end
      end
   end

   //********************
   // next grant
   //********************
   // idle   - take the pick, zero if nobody asks
   // busy   - keep the holder while its request stays up, others are ignored
   // release drops to zero, the new pick waits for the following edge
   always_comb begin
      if (busy) begin
         grant_nxt = grant_q & req_sync_i;  // holder bit falls with its request
      end else begin
         grant_nxt = pick;                  // may stay zero
      end
   end

   //********************
   // grant register
   //********************
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         grant_q <= '0;         // card free after reset
      end else begin
         grant_q <= grant_nxt;  // updates every edge
      end
   end

   // each controller reads its own bit of this vector and may drive
   // cs, mosi and sclk only while that bit is high
   assign grant_o = grant_q;

endmodule : sd_grant_arbiter

/* sd_req_sync.sv */
// request filter, one shift chain per controller, clocked by sdclock
// SYNC_STAGES must be 2 or more; output lags the sampled input by that many edges
module sd_req_sync
   import sd_share_pkg::*;
#(
   parameter int unsigned SYNC_STAGES = DEF_SYNC_STAGES  // chain depth
) (
   input  logic            sdclock,     // card clock
   input  logic            arst_n_i,    // async reset, active low
   input  logic [N_CH-1:0] req_i,       // raw request levels, any clock
   output logic [N_CH-1:0] req_sync_o   // filtered requests
);

   //********************
   // shift chains
   //********************
   // stage 0 samples the raw level, last stage feeds the arbiter
   logic [SYNC_STAGES-1:0][N_CH-1:0] sync_q;  // all channels side by side

   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sync_q <= '0;                               // no request seen after reset
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], req_i}; // shift one stage per edge
      end
   end

   //********************
   // output
   //********************
   // a short glitch on req_i that misses the sampling edge never
   // reaches the arbiter, a held level shows up SYNC_STAGES edges later
   assign req_sync_o = sync_q[SYNC_STAGES-1];  // oldest sample

endmodule : sd_req_sync

/* sd_share_pkg.sv */
// shared constants for the sd card sharing hub
// channel vectors are one bit per disk controller, bit 0 has top priority
package sd_share_pkg;

   //********************
   // channel map
   //********************
   localparam int unsigned N_CH  = 6;   // controllers sharing one card

   // bit index in every channel vector, lower index wins arbitration
   localparam int unsigned CH_RK = 0;   // rk11
   localparam int unsigned CH_DW = 1;   // dw
   localparam int unsigned CH_DM = 2;   // rk611
   localparam int unsigned CH_DB = 3;   // rh70
   localparam int unsigned CH_DX = 4;   // rx01
   localparam int unsigned CH_MY = 5;   // my

   //********************
   // defaults
   //********************
   // request filter depth, 2 flops minimum for a clean crossing
   localparam int unsigned DEF_SYNC_STAGES = 2;

   // controller whose spi lines drive the card while nobody holds a grant,
   // normally the one set up as spi master at power-up
   localparam int unsigned DEF_CH = CH_RK;

endpackage : sd_share_pkg
